/* testbench/boot_testdata.txt */
// Columns kind_op_address_data, kind 1 is an NBF record with op 3 write or op 0 finish
// Kind 2 gives a response index, counted from 0, that returns an error (index in data)
1_3_0080000000_0000029300000013
1_3_0080000008_0000031300000393
1_3_0080000010_00a0051300000593
1_3_0080000018_00b5063300c50663
1_3_0080000020_fff5859300058463
1_3_0080000028_0000006f00100073
1_3_0080000030_deadbeef00000000
1_3_0080000038_0000000000000001
1_3_0080001000_1122334455667788
1_3_0080001008_99aabbccddeeff00
1_3_0080001010_0f0f0f0ff0f0f0f0
1_3_0080001018_a5a5a5a55a5a5a5a
// Finish record
1_0_0000000000_0000000000000000
// Error responses
2_0_0000000000_0000000000000003
2_0_0000000000_000000000000000b

/* sources.f */
common/boot_map_pkg.sv
common/boot_msg_pkg.sv
hdl/cfg_loader.sv
hdl/nbf_loader.sv
hdl/boot_ctrl.sv
hdl/boot_loader_top.sv
testbench/boot_loader_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the boot loader testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module boot_loader_tb -f sources.f \
   && ./obj_dir/Vboot_loader_tb > sim.log 2>&1 \
   || echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* testbench/boot_loader_tb.sv */
/*
 * Boot loader testbench
 * Acts as the memory side of the command channel, feeds NBF records
 * from a data file and checks commands, done and error levels
 */
`timescale 1ns/1ps

module boot_loader_tb
   import boot_map_pkg::*;
   import boot_msg_pkg::*;
();

   localparam int data_lines = 64;

   logic    clk_i       = 1'b0;
   logic    rst_i       = 1'b1;
   logic    nbf_v_i     = 1'b0;
   logic    nbf_ready_o;
   nbf_op_e nbf_op_i    = nbf_finish;
   paddr_t  nbf_addr_i  = '0;
   dword_t  nbf_data_i  = '0;
   logic    cmd_v_o;
   mem_op_e cmd_op_o;
   paddr_t  cmd_addr_o;
   dword_t  cmd_data_o;
   logic    cmd_ready_i = 1'b0;
   logic    resp_v_i    = 1'b0;
   logic    resp_err_i  = 1'b0;
   logic    resp_ready_o;
   logic    boot_done_o;
   logic    boot_error_o;

   // Raw file lines and the tables taken from them
   logic [111:0] raw [data_lines];
   nbf_op_e      rec_op [data_lines];
   paddr_t       rec_addr [data_lines];
   dword_t       rec_data [data_lines];
   paddr_t       exp_addr [data_lines + cfg_entries];
   dword_t       exp_data [data_lines + cfg_entries];
   int           err_idx [data_lines];
   int           n_recs;
   int           n_exp;
   int           n_errs;
   logic         loaded    = 1'b0;
   logic         errors_on = 1'b0;

   // Memory model and monitor state
   logic [31:0] lfsr_state = 32'h16c62dec;
   int          rec_idx;
   int          exp_idx;
   int          pending;
   int          resp_count;
   int          resp_wait;
   logic        finish_taken;
   logic        err_seen;
   logic        done_seen;
   logic        cmd_fire;
   logic        resp_fire;
   logic        hold_v;
   mem_op_e     hold_op;
   paddr_t      hold_addr;
   dword_t      hold_data;

   boot_loader_top boot_loader_top_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .nbf_v_i      (nbf_v_i),
      .nbf_ready_o  (nbf_ready_o),
      .nbf_op_i     (nbf_op_i),
      .nbf_addr_i   (nbf_addr_i),
      .nbf_data_i   (nbf_data_i),
      .cmd_v_o      (cmd_v_o),
      .cmd_op_o     (cmd_op_o),
      .cmd_addr_o   (cmd_addr_o),
      .cmd_data_o   (cmd_data_o),
      .cmd_ready_i  (cmd_ready_i),
      .resp_v_i     (resp_v_i),
      .resp_err_i   (resp_err_i),
      .resp_ready_o (resp_ready_o),
      .boot_done_o  (boot_done_o),
      .boot_error_o (boot_error_o)
   );

   always #2 clk_i = ~clk_i;

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_paddr(input string name, input paddr_t exp, input paddr_t act);
      if (act !== exp)
         report_failure($sformatf("Error at %0t ns: %s expected %h, got %h",
                                  $time, name, exp, act));
   endtask

   task automatic check_dword(input string name, input dword_t exp, input dword_t act);
      if (act !== exp)
         report_failure($sformatf("Error at %0t ns: %s expected %h, got %h",
                                  $time, name, exp, act));
   endtask

   task automatic check_op(input string name, input mem_op_e exp, input mem_op_e act);
      if (act !== exp)
         report_failure($sformatf("Error at %0t ns: %s expected %0d, got %0d",
                                  $time, name, exp, act));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
         report_failure($sformatf("Error at %0t ns: %s expected %b, got %b",
                                  $time, name, exp, act));
   endtask

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic next_rand_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic response_has_error(input int idx);
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < n_errs; i++)
         if (err_idx[i] == idx)
            hit = 1'b1;
      return hit;
   endfunction

   task automatic load_testdata();
      for (int i = 0; i < data_lines; i++)
         raw[i] = '0;
      $readmemh("testbench/boot_testdata.txt", raw);
      n_recs = 0;
      n_exp  = 0;
      n_errs = 0;
      // Configuration writes come first, in table order
      for (int i = 0; i < cfg_entries; i++)
      begin
         exp_addr[n_exp] = cfg_base_addr + cfg_table_addr[i];
         exp_data[n_exp] = cfg_table_data[i];
         n_exp = n_exp + 1;
      end
      for (int i = 0; i < data_lines; i++)
      begin
         if (raw[i][111:108] == 4'h1)
         begin
            rec_op[n_recs]   = nbf_op_e'(raw[i][105:104]);
            rec_addr[n_recs] = raw[i][103:64];
            rec_data[n_recs] = raw[i][63:0];
            if (rec_op[n_recs] == nbf_write)
            begin
               exp_addr[n_exp] = rec_addr[n_recs];
               exp_data[n_exp] = rec_data[n_recs];
               n_exp = n_exp + 1;
            end
            n_recs = n_recs + 1;
         end
         else if (raw[i][111:108] == 4'h2)
         begin
            err_idx[n_errs] = int'(raw[i][31:0]);
            n_errs = n_errs + 1;
         end
      end
      if (n_recs == 0)
         report_failure("No NBF records were found in the data file");
   endtask

   task automatic apply_reset(input logic with_errors);
      @(posedge clk_i);
      rst_i <= 1'b1;
      repeat (9) @(posedge clk_i);
      // Idle levels while reset is held
      @(negedge clk_i);
      check_flag("nbf_ready_o", 1'b0, nbf_ready_o);
      check_flag("resp_ready_o", 1'b1, resp_ready_o);
      check_flag("boot_done_o", 1'b0, boot_done_o);
      check_flag("boot_error_o", 1'b0, boot_error_o);
      @(posedge clk_i);
      errors_on = with_errors;
      rst_i <= 1'b0;
   endtask

   task automatic finish_boot();
      @(negedge clk_i);
      while (!boot_done_o)
         @(negedge clk_i);
      // Give a stray command time to show up
      repeat (8) @(negedge clk_i);
      if (exp_idx != n_exp)
         report_failure($sformatf("Only %0d of %0d commands were issued", exp_idx, n_exp));
      if (rec_idx != n_recs)
         report_failure($sformatf("Only %0d of %0d NBF records were taken", rec_idx, n_recs));
      if (pending != 0)
         report_failure("Boot finished with commands still unanswered");
   endtask

   always @(posedge clk_i)
   begin
      if (rst_i)
      begin
         rec_idx      = 0;
         exp_idx      = 0;
         pending      = 0;
         resp_count   = 0;
         resp_wait    = 0;
         finish_taken = 1'b0;
         err_seen     = 1'b0;
         done_seen    = 1'b0;
         hold_v       = 1'b0;
         nbf_v_i     <= 1'b0;
         cmd_ready_i <= 1'b0;
         resp_v_i    <= 1'b0;
         resp_err_i  <= 1'b0;
      end
      else
      begin
         cmd_fire  = cmd_v_o && cmd_ready_i;
         resp_fire = resp_v_i && resp_ready_o;

         // Levels reflect what was accepted up to the previous edge
         check_flag("boot_error_o", err_seen, boot_error_o);
         if (done_seen)
            check_flag("boot_done_o", 1'b1, boot_done_o);
         else if (!(finish_taken && resp_count == n_exp))
            check_flag("boot_done_o", 1'b0, boot_done_o);
         if (boot_done_o)
            done_seen = 1'b1;

         // A stalled command must come back unchanged
         if (hold_v)
         begin
            check_flag("cmd_v_o", 1'b1, cmd_v_o);
            check_op("cmd_op_o", hold_op, cmd_op_o);
            check_paddr("cmd_addr_o", hold_addr, cmd_addr_o);
            check_dword("cmd_data_o", hold_data, cmd_data_o);
         end
         hold_v    = cmd_v_o && !cmd_ready_i;
         hold_op   = cmd_op_o;
         hold_addr = cmd_addr_o;
         hold_data = cmd_data_o;

         if (cmd_fire)
         begin
            if (boot_done_o)
               report_failure("A command was issued after boot_done_o rose");
            if (exp_idx >= n_exp)
               report_failure("More commands were issued than expected");
            check_op("cmd_op_o", op_write, cmd_op_o);
            check_paddr("cmd_addr_o", exp_addr[exp_idx], cmd_addr_o);
            check_dword("cmd_data_o", exp_data[exp_idx], cmd_data_o);
            exp_idx = exp_idx + 1;
            pending = pending + 1;
         end

         if (resp_fire)
         begin
            if (resp_err_i)
               err_seen = 1'b1;
            pending    = pending - 1;
            resp_count = resp_count + 1;
            resp_wait  = 0;
            if (next_rand_bit())
               resp_wait = resp_wait + 1;
            if (next_rand_bit())
               resp_wait = resp_wait + 2;
         end
         // One loader owns the channel at a time
         if (pending > max_credits)
            report_failure($sformatf("%0d commands are waiting for a response", pending));

         if (nbf_v_i && nbf_ready_o)
         begin
            if (nbf_op_i == nbf_finish)
               finish_taken = 1'b1;
            rec_idx = rec_idx + 1;
         end

         // Ready three cycles in four on average
         cmd_ready_i <= next_rand_bit() | next_rand_bit();

         if (!nbf_v_i || nbf_ready_o)
         begin
            if (rec_idx < n_recs && next_rand_bit())
            begin
               nbf_v_i    <= 1'b1;
               nbf_op_i   <= rec_op[rec_idx];
               nbf_addr_i <= rec_addr[rec_idx];
               nbf_data_i <= rec_data[rec_idx];
            end
            else
               nbf_v_i <= 1'b0;
         end

         // Answers in command order
         if (!resp_v_i || resp_fire)
         begin
            if (pending > 0 && resp_wait == 0)
            begin
               resp_v_i   <= 1'b1;
               resp_err_i <= errors_on && response_has_error(resp_count);
            end
            else
            begin
               resp_v_i   <= 1'b0;
               resp_err_i <= 1'b0;
               if (resp_wait > 0)
                  resp_wait = resp_wait - 1;
            end
         end
      end
   end

   initial
   begin
      load_testdata();
      loaded = 1'b1;
      apply_reset(1'b1);
      finish_boot();
      check_flag("boot_error_o", n_errs > 0, boot_error_o);
      // Second boot without error responses
      apply_reset(1'b0);
      finish_boot();
      check_flag("boot_error_o", 1'b0, boot_error_o);
      $display("Test OK");
      $finish;
   end

   initial
   begin
      wait (loaded);
      repeat (2 * (40 * n_recs + 40 * cfg_entries + 1000)) @(posedge clk_i);
      report_failure("Watchdog timeout, the boot did not complete in time");
   end

endmodule

/* hdl/boot_loader_top.sv */
/*
 * Boot loader top level
 * Configuration loader and NBF loader sharing one memory command
 * channel through the boot controller
 */
`timescale 1ns/1ps

module boot_loader_top
   import boot_map_pkg::*;
   import boot_msg_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,

   input  logic    nbf_v_i,
   output logic    nbf_ready_o,
   input  nbf_op_e nbf_op_i,
   input  paddr_t  nbf_addr_i,
   input  dword_t  nbf_data_i,

   output logic    cmd_v_o,
   output mem_op_e cmd_op_o,
   output paddr_t  cmd_addr_o,
   output dword_t  cmd_data_o,
   input  logic    cmd_ready_i,
   input  logic    resp_v_i,
   input  logic    resp_err_i,
   output logic    resp_ready_o,

   output logic    boot_done_o,
   output logic    boot_error_o
);

   logic    cfg_cmd_v;
   logic    cfg_cmd_ready;
   mem_op_e cfg_cmd_op;
   paddr_t  cfg_cmd_addr;
   dword_t  cfg_cmd_data;
   logic    cfg_resp_v;
   logic    cfg_resp_ready;
   logic    cfg_done;

   logic    nbf_cmd_v;
   logic    nbf_cmd_ready;
   mem_op_e nbf_cmd_op;
   paddr_t  nbf_cmd_addr;
   dword_t  nbf_cmd_data;
   logic    nbf_resp_v;
   logic    nbf_resp_ready;
   logic    nbf_done;
   logic    nbf_start;

   cfg_loader cfg_loader_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .cmd_v_o      (cfg_cmd_v),
      .cmd_ready_i  (cfg_cmd_ready),
      .cmd_op_o     (cfg_cmd_op),
      .cmd_addr_o   (cfg_cmd_addr),
      .cmd_data_o   (cfg_cmd_data),
      .resp_v_i     (cfg_resp_v),
      .resp_ready_o (cfg_resp_ready),
      .done_o       (cfg_done)
   );

   nbf_loader nbf_loader_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (nbf_start),
      .nbf_v_i      (nbf_v_i),
      .nbf_ready_o  (nbf_ready_o),
      .nbf_op_i     (nbf_op_i),
      .nbf_addr_i   (nbf_addr_i),
      .nbf_data_i   (nbf_data_i),
      .cmd_v_o      (nbf_cmd_v),
      .cmd_ready_i  (nbf_cmd_ready),
      .cmd_op_o     (nbf_cmd_op),
      .cmd_addr_o   (nbf_cmd_addr),
      .cmd_data_o   (nbf_cmd_data),
      .resp_v_i     (nbf_resp_v),
      .resp_ready_o (nbf_resp_ready),
      .done_o       (nbf_done)
   );

   boot_ctrl boot_ctrl_i (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .cfg_cmd_v_i      (cfg_cmd_v),
      .cfg_cmd_op_i     (cfg_cmd_op),
      .cfg_cmd_addr_i   (cfg_cmd_addr),
      .cfg_cmd_data_i   (cfg_cmd_data),
      .cfg_cmd_ready_o  (cfg_cmd_ready),
      .cfg_resp_v_o     (cfg_resp_v),
      .cfg_resp_ready_i (cfg_resp_ready),
      .cfg_done_i       (cfg_done),
      .nbf_cmd_v_i      (nbf_cmd_v),
      .nbf_cmd_op_i     (nbf_cmd_op),
      .nbf_cmd_addr_i   (nbf_cmd_addr),
      .nbf_cmd_data_i   (nbf_cmd_data),
      .nbf_cmd_ready_o  (nbf_cmd_ready),
      .nbf_resp_v_o     (nbf_resp_v),
      .nbf_resp_ready_i (nbf_resp_ready),
      .nbf_done_i       (nbf_done),
      .nbf_start_o      (nbf_start),
      .cmd_v_o          (cmd_v_o),
      .cmd_op_o         (cmd_op_o),
      .cmd_addr_o       (cmd_addr_o),
      .cmd_data_o       (cmd_data_o),
      .cmd_ready_i      (cmd_ready_i),
      .resp_v_i         (resp_v_i),
      .resp_err_i       (resp_err_i),
      .resp_ready_o     (resp_ready_o),
      .boot_done_o      (boot_done_o),
      .boot_error_o     (boot_error_o)
   );

endmodule

/* hdl/boot_ctrl.sv */
/*
 * Boot controller
 * Hands the shared memory channel to the configuration loader and then
 * to the NBF loader, steers responses to the current owner and keeps
 * a sticky error flag
 */
`timescale 1ns/1ps

module boot_ctrl
   import boot_map_pkg::*;
   import boot_msg_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,

   input  logic    cfg_cmd_v_i,
   input  mem_op_e cfg_cmd_op_i,
   input  paddr_t  cfg_cmd_addr_i,
   input  dword_t  cfg_cmd_data_i,
   output logic    cfg_cmd_ready_o,
   output logic    cfg_resp_v_o,
   input  logic    cfg_resp_ready_i,
   input  logic    cfg_done_i,

   input  logic    nbf_cmd_v_i,
   input  mem_op_e nbf_cmd_op_i,
   input  paddr_t  nbf_cmd_addr_i,
   input  dword_t  nbf_cmd_data_i,
   output logic    nbf_cmd_ready_o,
   output logic    nbf_resp_v_o,
   input  logic    nbf_resp_ready_i,
   input  logic    nbf_done_i,
   output logic    nbf_start_o,

   output logic    cmd_v_o,
   output mem_op_e cmd_op_o,
   output paddr_t  cmd_addr_o,
   output dword_t  cmd_data_o,
   input  logic    cmd_ready_i,
   input  logic    resp_v_i,
   input  logic    resp_err_i,
   output logic    resp_ready_o,

   output logic    boot_done_o,
   output logic    boot_error_o
);

   typedef enum logic [1:0] {
      ph_cfg,
      ph_nbf,
      ph_done
   } phase_e;

   phase_e phase_r;
   logic   err_r;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         phase_r <= ph_cfg;
      end
      else
      begin
         case (phase_r)
            ph_cfg:
            begin
               if (cfg_done_i)
                  phase_r <= ph_nbf;
            end
            ph_nbf:
            begin
               if (nbf_done_i)
                  phase_r <= ph_done;
            end
            default:
            begin
               phase_r <= ph_done;
            end
         endcase
      end
   end

   // Fixed arbitration, the phases never overlap
   always_comb
   begin
      cmd_v_o         = 1'b0;
      cmd_op_o        = nbf_cmd_op_i;
      cmd_addr_o      = nbf_cmd_addr_i;
      cmd_data_o      = nbf_cmd_data_i;
      cfg_cmd_ready_o = 1'b0;
      nbf_cmd_ready_o = 1'b0;
      cfg_resp_v_o    = 1'b0;
      nbf_resp_v_o    = 1'b0;
      resp_ready_o    = 1'b0;
      case (phase_r)
         ph_cfg:
         begin
            cmd_v_o         = cfg_cmd_v_i;
            cmd_op_o        = cfg_cmd_op_i;
            cmd_addr_o      = cfg_cmd_addr_i;
            cmd_data_o      = cfg_cmd_data_i;
            cfg_cmd_ready_o = cmd_ready_i;
            cfg_resp_v_o    = resp_v_i;
            resp_ready_o    = cfg_resp_ready_i;
         end
         ph_nbf:
         begin
            cmd_v_o         = nbf_cmd_v_i;
            nbf_cmd_ready_o = cmd_ready_i;
            nbf_resp_v_o    = resp_v_i;
            resp_ready_o    = nbf_resp_ready_i;
         end
         default:
         begin
            cmd_v_o = 1'b0;
         end
      endcase
   end

   // Any error response sticks until reset
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         err_r <= 1'b0;
      else if (resp_v_i && resp_ready_o && resp_err_i)
         err_r <= 1'b1;
   end

   assign nbf_start_o  = (phase_r == ph_nbf);
   assign boot_done_o  = (phase_r == ph_done);
   assign boot_error_o = err_r;

   // Every command was answered before the last loader reported done
   no_resp_after_done_a: assert property (@(posedge clk_i) disable iff (rst_i)
      (phase_r == ph_done) |-> !resp_v_i);

endmodule

/* hdl/nbf_loader.sv */
/*
 * NBF loader
 * Forwards incoming NBF write records as write commands once started,
 * stops on the finish record and raises done when every write has
 * been answered
 */
`timescale 1ns/1ps

module nbf_loader
   import boot_map_pkg::*;
   import boot_msg_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,

   input  logic    start_i,

   input  logic    nbf_v_i,
   output logic    nbf_ready_o,
   input  nbf_op_e nbf_op_i,
   input  paddr_t  nbf_addr_i,
   input  dword_t  nbf_data_i,

   output logic    cmd_v_o,
   input  logic    cmd_ready_i,
   output mem_op_e cmd_op_o,
   output paddr_t  cmd_addr_o,
   output dword_t  cmd_data_o,

   input  logic    resp_v_i,
   output logic    resp_ready_o,

   output logic    done_o
);

   typedef enum logic [1:0] {
      st_idle,
      st_load,
      st_drain,
      st_done
   } state_e;

   state_e  state_r;
   credit_t credits_r;
   credit_t credits_next;
   logic    loading;
   logic    credit_free;
   logic    send;
   logic    recv;
   logic    take_finish;

   assign loading     = (state_r == st_load);
   assign credit_free = (credits_r < credit_t'(max_credits));

   // Records only move when the command side can take a write in the same cycle
   assign nbf_ready_o = start_i & loading & credit_free & cmd_ready_i;

   // Write records pass straight through to the command channel
   assign cmd_v_o    = loading & nbf_v_i & (nbf_op_i == nbf_write) & credit_free;
   assign cmd_op_o   = op_write;
   assign cmd_addr_o = nbf_addr_i;
   assign cmd_data_o = nbf_data_i;

   assign resp_ready_o = (state_r == st_load) || (state_r == st_drain);

   assign send        = cmd_v_o & cmd_ready_i;
   assign recv        = resp_v_i & resp_ready_o;
   assign take_finish = nbf_v_i & nbf_ready_o & (nbf_op_i == nbf_finish);

   assign credits_next = credits_r + credit_t'(send) - credit_t'(recv);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_r   <= st_idle;
         credits_r <= '0;
      end
      else
      begin
         credits_r <= credits_next;
         case (state_r)
            st_idle:
            begin
               if (start_i)
                  state_r <= st_load;
            end
            st_load:
            begin
               if (take_finish)
                  state_r <= st_drain;
            end
            st_drain:
            begin
               if (credits_next == '0)
                  state_r <= st_done;
            end
            default:
            begin
               state_r <= st_done;
            end
         endcase
      end
   end

   assign done_o = (state_r == st_done);

   credit_bound_a: assert property (@(posedge clk_i) disable iff (rst_i)
      credits_r <= credit_t'(max_credits));

   // The controller must hold start until this loader has finished
   cmd_needs_start_a: assert property (@(posedge clk_i) disable iff (rst_i)
      cmd_v_o |-> start_i);

endmodule

/* hdl/cfg_loader.sv */
/*
 * Configuration loader
 * Walks the fixed configuration table and issues one write per entry,
 * keeping at most max_credits writes in flight, then waits for all
 * responses before raising done
 */
`timescale 1ns/1ps

module cfg_loader
   import boot_map_pkg::*;
   import boot_msg_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,

   output logic    cmd_v_o,
   input  logic    cmd_ready_i,
   output mem_op_e cmd_op_o,
   output paddr_t  cmd_addr_o,
   output dword_t  cmd_data_o,

   input  logic    resp_v_i,
   output logic    resp_ready_o,

   output logic    done_o
);

   typedef logic [$clog2(cfg_entries)-1:0] cfg_idx_t;

   typedef enum logic [1:0] {
      st_issue,
      st_drain,
      st_done
   } state_e;

   state_e   state_r;
   cfg_idx_t idx_r;
   credit_t  credits_r;
   credit_t  credits_next;
   logic     send;
   logic     recv;
   logic     last_entry;

   // Current table entry as a write into configuration space
   assign cmd_v_o    = (state_r == st_issue) && (credits_r < credit_t'(max_credits));
   assign cmd_op_o   = op_write;
   assign cmd_addr_o = cfg_base_addr + cfg_table_addr[idx_r];
   assign cmd_data_o = cfg_table_data[idx_r];

   assign resp_ready_o = (state_r != st_done);

   assign send       = cmd_v_o & cmd_ready_i;
   assign recv       = resp_v_i & resp_ready_o;
   assign last_entry = (idx_r == cfg_idx_t'(cfg_entries - 1));

   assign credits_next = credits_r + credit_t'(send) - credit_t'(recv);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_r   <= st_issue;
         idx_r     <= '0;
         credits_r <= '0;
      end
      else
      begin
         credits_r <= credits_next;
         case (state_r)
            st_issue:
            begin
               if (send)
               begin
                  idx_r <= idx_r + 1'b1;
                  if (last_entry)
                     state_r <= st_drain;
               end
            end
            st_drain:
            begin
               if (credits_next == '0)
                  state_r <= st_done;
            end
            default:
            begin
               state_r <= st_done;
            end
         endcase
      end
   end

   assign done_o = (state_r == st_done);

   credit_bound_a: assert property (@(posedge clk_i) disable iff (rst_i)
      credits_r <= credit_t'(max_credits));

endmodule

/* common/boot_msg_pkg.sv */
/*
 * Boot message encodings
 * Memory command opcodes, NBF record opcodes and the per-loader
 * limit on outstanding commands
 */
package boot_msg_pkg;

   // Memory command opcode
   typedef enum logic [1:0] {
      op_read  = 2'b00,
      op_write = 2'b01
   } mem_op_e;

   // NBF record opcode, 8-byte write or end of program
   typedef enum logic [1:0] {
      nbf_finish = 2'b00,
      nbf_write  = 2'b11
   } nbf_op_e;

   localparam int max_credits = 4;

   // Wide enough to hold max_credits itself
   typedef logic [2:0] credit_t;

endpackage

/* common/boot_map_pkg.sv */
/*
 * Boot address map
 * Physical address and data widths, the base of the configuration
 * register space and the fixed table written there at boot
 */
package boot_map_pkg;

   // Physical address and command data word
   typedef logic [39:0] paddr_t;
   typedef logic [63:0] dword_t;

   localparam paddr_t cfg_base_addr = 40'h00_0020_0000;

   localparam int cfg_entries = 6;

   // Offsets from cfg_base_addr, in table order
   localparam paddr_t cfg_table_addr [cfg_entries] = '{
      40'h00_0000_0000,  // freeze
      40'h00_0000_0008,  // core id
      40'h00_0000_0010,  // domain id
      40'h00_0000_0018,  // coherence mode
      40'h00_0000_0020,  // instruction RAM base
      40'h00_0000_0028   // scratch
   };

   localparam dword_t cfg_table_data [cfg_entries] = '{
      64'h0000_0000_0000_0001,
      64'h0000_0000_0000_0000,
      64'h0000_0000_0000_0000,
      64'h0000_0000_0000_0001,
      64'h0000_0000_8000_0000,
      64'h0123_4567_89ab_cdef
   };

endpackage
